/* flist.f */
hdl/snes_glue_pkg.sv
hdl/snes_glue_if.sv
hdl/rom_load_seq.sv
hdl/mem_req_mux.sv
hdl/vram_read_filter.sv
hdl/read_lane_steer.sv
hdl/snes_mem_glue.sv
test/snes_mem_glue_assertions.sv
test/tb_snes_mem_glue.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_snes_mem_glue
FLIST     ?= flist.f
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* test/tb_snes_mem_glue.sv */
// testbench for the snes memory glue with seeded random stimulus checked against a cycle model
module tb_snes_mem_glue;
    localparam int body_max   = 300;
    localparam int max_cycles = 3 + (snes_glue_pkg::header_bytes + body_max) * 5 + 20
                                + 200 + 600 + 3 * 200 + 200 + 100;   // load then four phases

    logic        resetn, rom_loading, rom_byte_valid, mem_busy, frame_pause;
    logic        sysclkf_ce, sysclkr_ce, rom_ce_n, rom_word, wram_ce_n, wram_rd_n, wram_we_n;
    logic        vram_oe_n, aram_ce_n, aram_oe_n;
    logic        mclk = 1'b0;
    logic [7:0]  rom_byte, wram_d;
    logic [23:0] rom_addr;
    logic [16:0] wram_addr;
    logic [15:0] vram1_addr, vram2_addr, aram_addr, mem_port0, mem_port1, aram_dout;
    logic        core_resetn, enable, loaded, mem_port, mem_rd, mem_wr, vram1_rd, vram2_rd;
    logic [22:0] mem_addr;
    logic [15:0] mem_din, rom_q;
    logic [1:0]  mem_ds;
    logic [7:0]  wram_q, aram_q;

    // reference model state
    logic        m_loading_q, m_loaded, m_enable, m_f2, m_r2, m_second, m_rd, m_wr, m_port;
    logic        m_oe_q, m_defer_q, m_aram_hi, m_aram_seen;
    logic [22:0] m_addr;
    logic [15:0] m_din;
    logic [1:0]  m_ds;
    logic [14:0] m_a1_q, m_a2_q;
    int          m_idx;          // valid bytes since loading rose
    int          cycles = 0;
    logic        e_strobe, e_new1, e_new2, e_defer;

    // model terms that follow the inputs within a cycle
    assign e_strobe = rom_loading & m_loading_q & rom_byte_valid
                      & (m_idx >= snes_glue_pkg::header_bytes);
    assign e_new1   = ~vram_oe_n & (m_oe_q | (m_a1_q != vram1_addr[14:0]));
    assign e_new2   = ~vram_oe_n & (m_oe_q | (m_a2_q != vram2_addr[14:0]));
    assign e_defer  = e_new1 & e_new2 & (vram1_addr != vram2_addr);

    snes_mem_glue UUT (.*);

    always #2 mclk = ~mclk;

    always @(posedge mclk) begin
        cycles <= cycles + 1;
        if (cycles > max_cycles) begin
            $display("timeout: test did not finish within %0d cycles", max_cycles);
            $display("TEST FAIL");
            $fatal(1, "run stopped by timeout");
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error %s: got %h expected %h", name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // a byte read at an odd address returns its byte on the low lane
    function automatic logic [15:0] rom_lane_swap(input logic [15:0] word, input logic byte_rd,
                                                  input logic odd);
        if (byte_rd && odd)
            return {word[7:0], word[15:8]};
        return word;
    endfunction

    function automatic logic [7:0] select_byte(input logic [15:0] word, input logic hi);
        return word[8*hi +: 8];
    endfunction

    // advance the model at the edge while inputs still hold this cycle's values
    task automatic model_clock;
        logic wrd;
        logic wwr;
        wrd = ~wram_ce_n & ~wram_rd_n;
        wwr = ~wram_ce_n & ~wram_we_n;
        if (!resetn) begin
            {m_loading_q, m_loaded, m_enable, m_f2, m_r2} = '0;
            {m_second, m_rd, m_wr, m_defer_q} = '0;
            m_oe_q = 1'b1;
            m_idx  = 0;
        end else begin
            m_defer_q = e_defer;
            m_rd      = 1'b0;
            m_wr      = 1'b0;
            if (m_second) begin
                m_wr     = 1'b1;   // second half of a loader write
                m_second = 1'b0;
            end else if (e_strobe) begin
                m_wr     = 1'b1;
                m_second = 1'b1;
                m_addr   = 23'(m_idx - snes_glue_pkg::header_bytes);
                m_din    = {rom_byte, rom_byte};
                m_ds     = {m_addr[0], ~m_addr[0]};
                m_port   = 1'b0;
            end else if (wrd | wwr) begin
                m_rd   = wrd & m_f2;
                m_wr   = wwr & m_r2 & ~(wrd & m_f2);
                m_addr = {6'h3f, wram_addr};   // top of the map
                m_din  = {wram_d, wram_d};
                m_ds   = {wram_addr[0], ~wram_addr[0]};
                m_port = 1'b1;
            end else if (!rom_ce_n && m_f2) begin
                m_rd   = 1'b1;
                m_addr = rom_addr[22:0];
                m_ds   = 2'b11;
                m_port = 1'b0;
            end
            m_f2     = sysclkf_ce & m_enable;
            m_r2     = sysclkr_ce & m_enable;
            m_enable = m_loaded & ~mem_busy & ~frame_pause;
            if (rom_loading && !m_loading_q) begin
                m_loaded = 1'b0;
                m_idx    = rom_byte_valid ? 1 : 0;
            end else if (!rom_loading && m_loading_q) begin
                m_loaded = 1'b1;
            end else if (rom_loading && rom_byte_valid) begin
                m_idx = m_idx + 1;
            end
            m_loading_q = rom_loading;
            m_oe_q      = vram_oe_n;
        end
        m_a1_q = vram1_addr[14:0];
        m_a2_q = vram2_addr[14:0];
        if (!aram_ce_n && !aram_oe_n) begin
            m_aram_hi   = aram_addr[0];
            m_aram_seen = 1'b1;
        end
    endtask

    task automatic next_cycle;
        @(posedge mclk);
        model_clock();
        #1;                  // drive point
    endtask

    // every output is settled by mid cycle
    task automatic settle_check;
        @(negedge mclk);
        check("core_resetn", 32'(core_resetn), 32'(resetn & ~rom_loading));
        check("loaded", 32'(loaded), 32'(m_loaded));
        check("enable", 32'(enable), 32'(m_enable));
        check("mem_rd", 32'(mem_rd), 32'(m_rd));
        check("mem_wr", 32'(mem_wr), 32'(m_wr));
        if (m_rd || m_wr) begin
            check("mem_addr", 32'(mem_addr), 32'(m_addr));
            check("mem_ds", 32'(mem_ds), 32'(m_ds));
            check("mem_port", 32'(mem_port), 32'(m_port));
        end
        if (m_wr)
            check("mem_din", 32'(mem_din), 32'(m_din));
        check("vram1_rd", 32'(vram1_rd), 32'(e_new1));
        check("vram2_rd", 32'(vram2_rd), 32'((e_new2 & ~e_defer) | m_defer_q));
        check("rom_q", 32'(rom_q), 32'(rom_lane_swap(mem_port0, ~rom_word, rom_addr[0])));
        check("wram_q", 32'(wram_q), 32'(select_byte(mem_port1, wram_addr[0])));
        if (m_aram_seen)
            check("aram_q", 32'(aram_q), 32'(select_byte(aram_dout, m_aram_hi)));
    endtask

    task automatic hold_cycles(input int n);
        repeat (n) begin
            next_cycle();
            settle_check();
        end
    endtask

    initial begin
        int n_bytes;
        void'($urandom(32'h0062_2c65));
        m_aram_seen = 1'b0;
        resetn      = 1'b0;
        {rom_loading, rom_byte_valid, mem_busy, frame_pause, sysclkf_ce, sysclkr_ce} = '0;
        {rom_ce_n, wram_ce_n, wram_rd_n, wram_we_n, vram_oe_n, aram_ce_n, aram_oe_n} = '1;
        {rom_word, rom_byte, wram_d, rom_addr, wram_addr} = '0;
        {vram1_addr, vram2_addr, aram_addr, mem_port0, mem_port1, aram_dout} = '0;
        repeat (3) next_cycle();
        resetn = 1'b1;
        settle_check();

        // header plus 100..300 body bytes with two to four idle cycles between bytes
        n_bytes = snes_glue_pkg::header_bytes + 100 + int'($urandom % 201);
        next_cycle();
        rom_loading = 1'b1;
        settle_check();
        for (int i = 0; i < n_bytes; i++) begin
            next_cycle();
            rom_byte       = 8'($urandom);
            rom_byte_valid = 1'b1;
            settle_check();
            next_cycle();
            rom_byte_valid = 1'b0;
            settle_check();
            hold_cycles(1 + int'($urandom % 3));
        end
        hold_cycles(3);
        next_cycle();
        rom_loading = 1'b0;
        settle_check();
        hold_cycles(3);

        // enable under random busy and pause
        for (int i = 0; i < 200; i++) begin
            next_cycle();
            mem_busy    = ($urandom % 2) == 0;
            frame_pause = ($urandom % 3) == 0;
            settle_check();
        end

        // arbitration between work RAM and ROM
        for (int i = 0; i < 600; i++) begin
            next_cycle();
            mem_busy    = ($urandom % 8) == 0;
            frame_pause = ($urandom % 8) == 0;
            sysclkf_ce  = ($urandom % 3) == 0;
            sysclkr_ce  = ($urandom % 3) == 0;
            rom_ce_n    = ($urandom % 2) == 0;
            wram_ce_n   = ($urandom % 3) != 0;
            wram_rd_n   = ($urandom % 2) == 0;
            wram_we_n   = ($urandom % 2) == 0;
            rom_addr    = 24'($urandom);
            wram_addr   = 17'($urandom);
            wram_d      = 8'($urandom);
            settle_check();
        end
        next_cycle();
        {rom_ce_n, wram_ce_n} = 2'b11;
        settle_check();

        // vram reads from a small address set, each set held three cycles
        for (int i = 0; i < 200; i++) begin
            next_cycle();
            vram_oe_n  = ($urandom % 4) == 0;
            vram1_addr = {1'($urandom), 13'h0, 2'($urandom)};
            vram2_addr = ($urandom % 3 == 0) ? vram1_addr : {1'($urandom), 13'h0, 2'($urandom)};
            settle_check();
            hold_cycles(2);
        end
        next_cycle();
        vram_oe_n = 1'b1;
        settle_check();

        // read lanes
        for (int i = 0; i < 200; i++) begin
            next_cycle();
            mem_port0 = 16'($urandom);
            mem_port1 = 16'($urandom);
            aram_dout = 16'($urandom);
            rom_addr  = 24'($urandom);
            rom_word  = ($urandom % 2) == 0;
            wram_addr = 17'($urandom);
            aram_ce_n = ($urandom % 2) == 0;
            aram_oe_n = ($urandom % 2) == 0;
            aram_addr = 16'($urandom);
            settle_check();
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

/* test/snes_mem_glue_assertions.sv */
// concurrent checks on the memory request port and the vram read filter of the snes glue
module snes_mem_glue_assertions (
    input logic                    mclk,
    input logic                    resetn,
    input logic                    mem_rd,
    input logic                    mem_wr,
    input logic                    vram2_rd,
    input snes_glue_pkg::req_src_e src
);
    logic ld_wr;   // write issued for a loader byte

    assign ld_wr = mem_wr && (src == snes_glue_pkg::src_loader);

    // one request per cycle on the shared port
    rd_wr_exclusive: assert property (@(posedge mclk) disable iff (!resetn) !(mem_rd && mem_wr))
        else $error("mem_rd and mem_wr are high in the same cycle");

    // a deferred port 2 read never runs into the next one
    vram2_single: assert property (@(posedge mclk) disable iff (!resetn) vram2_rd |=> !vram2_rd)
        else $error("vram2_rd is high in two consecutive cycles");

    loader_wr_two: assert property (@(posedge mclk) disable iff (!resetn)
        $rose(ld_wr) |=> ld_wr ##1 !ld_wr)
        else $error("loader write did not last exactly two cycles");

endmodule

bind snes_mem_glue snes_mem_glue_assertions u_assertions (
    .mclk     (mclk),
    .resetn   (resetn),
    .mem_rd   (mem_rd),
    .mem_wr   (mem_wr),
    .vram2_rd (vram2_rd),
    .src      (req_bus.source)
);

/* hdl/snes_mem_glue.sv */
// snes memory glue top with rom loader, request mux, vram read filter and read lane steering
module snes_mem_glue (
    input  logic                                   resetn,
    input  logic                                   mclk,
    input  logic                                   rom_loading,
    input  logic [7:0]                             rom_byte,
    input  logic                                   rom_byte_valid,
    input  logic                                   mem_busy,
    input  logic                                   frame_pause,
    input  logic                                   sysclkf_ce,
    input  logic                                   sysclkr_ce,
    input  logic                                   rom_ce_n,
    input  logic [snes_glue_pkg::rom_addr_w-1:0]   rom_addr,
    input  logic                                   rom_word,
    input  logic                                   wram_ce_n,
    input  logic                                   wram_rd_n,
    input  logic                                   wram_we_n,
    input  logic [snes_glue_pkg::wram_addr_w-1:0]  wram_addr,
    input  logic [7:0]                             wram_d,
    input  logic                                   vram_oe_n,
    input  logic [15:0]                            vram1_addr,
    input  logic [15:0]                            vram2_addr,
    input  logic                                   aram_ce_n,
    input  logic                                   aram_oe_n,
    input  logic [15:0]                            aram_addr,
    input  logic [15:0]                            mem_port0,
    input  logic [15:0]                            mem_port1,
    input  logic [15:0]                            aram_dout,
    output logic                                   core_resetn,
    output logic                                   enable,
    output logic                                   loaded,
    output logic [snes_glue_pkg::mem_addr_w-1:0]   mem_addr,
    output logic [15:0]                            mem_din,
    output logic [1:0]                             mem_ds,
    output logic                                   mem_port,
    output logic                                   mem_rd,
    output logic                                   mem_wr,
    output logic                                   vram1_rd,
    output logic                                   vram2_rd,
    output logic [15:0]                            rom_q,
    output logic [7:0]                             wram_q,
    output logic [7:0]                             aram_q
);
    logic aram_rd_n;   // audio RAM read when both selects are low

    load_wr_if ld_bus ();
    mem_req_if req_bus ();

    assign aram_rd_n = aram_ce_n | aram_oe_n;

    assign mem_addr = req_bus.addr;
    assign mem_din  = req_bus.din;
    assign mem_ds   = req_bus.ds;
    assign mem_port = req_bus.port;
    assign mem_rd   = req_bus.rd;
    assign mem_wr   = req_bus.wr;

    rom_load_seq u_load (
        .mclk        (mclk),
        .resetn      (resetn),
        .loading     (rom_loading),
        .byte_in     (rom_byte),
        .byte_valid  (rom_byte_valid),
        .wr          (ld_bus.src),
        .loaded      (loaded),
        .core_resetn (core_resetn)
    );

    mem_req_mux u_mux (
        .mclk        (mclk),
        .resetn      (resetn),
        .ld          (ld_bus.dst),
        .loaded      (loaded),
        .mem_busy    (mem_busy),
        .frame_pause (frame_pause),
        .sysclkf_ce  (sysclkf_ce),
        .sysclkr_ce  (sysclkr_ce),
        .rom_ce_n    (rom_ce_n),
        .rom_addr    (rom_addr),
        .wram_ce_n   (wram_ce_n),
        .wram_rd_n   (wram_rd_n),
        .wram_we_n   (wram_we_n),
        .wram_addr   (wram_addr),
        .wram_d      (wram_d),
        .req         (req_bus.src),
        .enable      (enable)
    );

    vram_read_filter u_vram (
        .mclk   (mclk),
        .resetn (resetn),
        .oe_n   (vram_oe_n),
        .addr1  (vram1_addr),
        .addr2  (vram2_addr),
        .rd1    (vram1_rd),
        .rd2    (vram2_rd)
    );

    read_lane_steer u_lanes (
        .mclk       (mclk),
        .port0      (mem_port0),
        .port1      (mem_port1),
        .aram_dout  (aram_dout),
        .rom_addr0  (rom_addr[0]),
        .rom_word   (rom_word),
        .wram_addr0 (wram_addr[0]),
        .aram_rd_n  (aram_rd_n),
        .aram_addr0 (aram_addr[0]),
        .rom_q      (rom_q),
        .wram_q     (wram_q),
        .aram_q     (aram_q)
    );

endmodule

/* hdl/read_lane_steer.sv */
// read lane steering with byte swap and byte select of memory read data back to the core
module read_lane_steer (
    input  logic        mclk,
    input  logic [15:0] port0,
    input  logic [15:0] port1,
    input  logic [15:0] aram_dout,
    input  logic        rom_addr0,
    input  logic        rom_word,
    input  logic        wram_addr0,
    input  logic        aram_rd_n,
    input  logic        aram_addr0,
    output logic [15:0] rom_q,
    output logic [7:0]  wram_q,
    output logic [7:0]  aram_q
);
    logic aram_hi;   // byte chosen at the last audio RAM read

    // odd byte access to rom wants its byte on the low lane
    assign rom_q = (rom_word || !rom_addr0) ? port0 : {port0[7:0], port0[15:8]};

    assign wram_q = wram_addr0 ? port1[15:8] : port1[7:0];

    // lane is latched since aram data returns after the read strobe
    always_ff @(posedge mclk) begin
        if (!aram_rd_n)
            aram_hi <= aram_addr0;
    end

    assign aram_q = aram_hi ? aram_dout[15:8] : aram_dout[7:0];

endmodule

/* hdl/vram_read_filter.sv */
// vram read filter that drops repeated reads and moves a conflicting port 2 read one cycle later
module vram_read_filter (
    input  logic        mclk,
    input  logic        resetn,
    input  logic        oe_n,
    input  logic [15:0] addr1,
    input  logic [15:0] addr2,
    output logic        rd1,
    output logic        rd2
);
    logic                                  oe_n_q;
    logic [snes_glue_pkg::vram_addr_w-1:0] addr1_q;
    logic [snes_glue_pkg::vram_addr_w-1:0] addr2_q;
    logic                                  new1;
    logic                                  new2;
    logic                                  defer;
    logic                                  defer_q;   // port 2 read owed from last cycle

    // a read is new when oe_n just fell or the address moved
    assign new1 = ~oe_n & (oe_n_q | (addr1_q != addr1[snes_glue_pkg::vram_addr_w-1:0]));
    assign new2 = ~oe_n & (oe_n_q | (addr2_q != addr2[snes_glue_pkg::vram_addr_w-1:0]));

    // port 2 waits a cycle when both ports want different words
    assign defer = new1 & new2 & (addr1 != addr2);

    assign rd1 = new1;
    assign rd2 = (new2 & ~defer) | defer_q;

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            oe_n_q  <= 1'b1;
            defer_q <= 1'b0;
        end else begin
            oe_n_q  <= oe_n;
            defer_q <= defer;
        end
    end

    always_ff @(posedge mclk) begin
        addr1_q <= addr1[snes_glue_pkg::vram_addr_w-1:0];
        addr2_q <= addr2[snes_glue_pkg::vram_addr_w-1:0];
    end

endmodule

/* hdl/mem_req_mux.sv */
// memory request mux for run enable, phase strobes and the prioritised single memory port
module mem_req_mux (
    input  logic                                   mclk,
    input  logic                                   resetn,
    load_wr_if.dst                                 ld,
    input  logic                                   loaded,
    input  logic                                   mem_busy,
    input  logic                                   frame_pause,
    input  logic                                   sysclkf_ce,
    input  logic                                   sysclkr_ce,
    input  logic                                   rom_ce_n,
    input  logic [snes_glue_pkg::rom_addr_w-1:0]   rom_addr,
    input  logic                                   wram_ce_n,
    input  logic                                   wram_rd_n,
    input  logic                                   wram_we_n,
    input  logic [snes_glue_pkg::wram_addr_w-1:0]  wram_addr,
    input  logic [7:0]                             wram_d,
    mem_req_if.src                                 req,
    output logic                                   enable
);
    logic f2;           // falling phase of an enabled cycle delayed one mclk
    logic r2;           // rising phase likewise
    logic ld_second;    // second cycle of a loader write
    logic ld_take;
    logic wram_rd;
    logic wram_wr;
    logic wram_sel;
    logic rom_take;

    assign ld_take  = ld.strobe & ld.active;
    assign wram_rd  = ~wram_ce_n & ~wram_rd_n;
    assign wram_wr  = ~wram_ce_n & ~wram_we_n;
    assign wram_sel = wram_rd | wram_wr;
    assign rom_take = ~rom_ce_n & f2;   // rom reads on f cycles

    // enable, phases and the request pulses
    always_ff @(posedge mclk) begin
        if (!resetn) begin
            enable     <= 1'b0;
            f2         <= 1'b0;
            r2         <= 1'b0;
            ld_second  <= 1'b0;
            req.rd     <= 1'b0;
            req.wr     <= 1'b0;
            req.source <= snes_glue_pkg::src_none;
        end else begin
            enable     <= loaded & ~mem_busy & ~frame_pause;
            f2         <= sysclkf_ce & enable;
            r2         <= sysclkr_ce & enable;
            ld_second  <= 1'b0;
            req.rd     <= 1'b0;
            req.wr     <= 1'b0;
            req.source <= snes_glue_pkg::src_none;

            // loader bytes are expected at least two cycles apart
            if (ld_second) begin
                req.wr     <= 1'b1;
                req.source <= snes_glue_pkg::src_loader;
            end else if (ld_take) begin
                req.wr     <= 1'b1;
                req.source <= snes_glue_pkg::src_loader;
                ld_second  <= 1'b1;
            end else if (wram_sel) begin
                if (wram_rd && f2) begin
                    req.rd     <= 1'b1;
                    req.source <= snes_glue_pkg::src_wram;
                end else if (wram_wr && r2) begin
                    req.wr     <= 1'b1;
                    req.source <= snes_glue_pkg::src_wram;
                end
            end else if (rom_take) begin
                req.rd     <= 1'b1;
                req.source <= snes_glue_pkg::src_rom;
            end
        end
    end

    // request payload held through the loader's second write cycle
    always_ff @(posedge mclk) begin
        if (!ld_second) begin
            if (ld_take) begin
                req.addr <= ld.addr;
                req.din  <= {ld.data, ld.data};            // same byte on both lanes
                req.ds   <= {ld.addr[0], ~ld.addr[0]};
                req.port <= snes_glue_pkg::port_rom;
            end else if (wram_sel) begin
                req.addr <= {snes_glue_pkg::wram_base, wram_addr};  // 7E/7F banks
                req.din  <= {wram_d, wram_d};
                req.ds   <= {wram_addr[0], ~wram_addr[0]};
                req.port <= snes_glue_pkg::port_wram;
            end else if (rom_take) begin
                req.addr <= rom_addr[snes_glue_pkg::mem_addr_w-1:0];
                req.ds   <= 2'b11;                          // full word
                req.port <= snes_glue_pkg::port_rom;
            end
        end
    end

endmodule

/* hdl/rom_load_seq.sv */
// rom load sequencer that drops the cartridge header and writes the image body bytes
module rom_load_seq (
    input  logic       mclk,
    input  logic       resetn,
    input  logic       loading,
    input  logic [7:0] byte_in,
    input  logic       byte_valid,
    load_wr_if.src     wr,
    output logic       loaded,
    output logic       core_resetn
);
    snes_glue_pkg::load_state_e                state;
    logic                                      loading_q;
    logic [snes_glue_pkg::header_cnt_w-1:0]    hdr_cnt;
    logic [snes_glue_pkg::mem_addr_w-1:0]      load_addr;
    logic                                      load_rise;
    logic                                      load_fall;

    assign load_rise = loading & ~loading_q;
    assign load_fall = ~loading & loading_q;

    // core stays in reset for the whole load
    assign core_resetn = resetn & ~loading;

    assign wr.data   = byte_in;
    assign wr.addr   = load_addr;
    assign wr.strobe = loading & byte_valid & (state == snes_glue_pkg::ld_body);
    assign wr.active = (state == snes_glue_pkg::ld_header) || (state == snes_glue_pkg::ld_body);

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            state     <= snes_glue_pkg::ld_idle;
            loading_q <= 1'b0;
            hdr_cnt   <= '0;
            load_addr <= '0;
            loaded    <= 1'b0;
        end else begin
            loading_q <= loading;
            case (state)
                snes_glue_pkg::ld_idle, snes_glue_pkg::ld_done: begin
                    if (load_rise) begin
                        state      <= snes_glue_pkg::ld_header;
                        load_addr  <= '0;
                        loaded     <= 1'b0;
                        hdr_cnt    <= '0;
                        hdr_cnt[0] <= byte_valid;   // first byte may come with the edge
                    end
                end
                snes_glue_pkg::ld_header: begin
                    if (load_fall) begin
                        state  <= snes_glue_pkg::ld_done;   // short image with header only
                        loaded <= 1'b1;
                    end else if (byte_valid) begin
                        if (hdr_cnt == snes_glue_pkg::header_last)
                            state <= snes_glue_pkg::ld_body;
                        hdr_cnt <= hdr_cnt + 1'b1;
                    end
                end
                snes_glue_pkg::ld_body: begin
                    if (load_fall) begin
                        state  <= snes_glue_pkg::ld_done;
                        loaded <= 1'b1;
                    end else if (wr.strobe) begin
                        load_addr <= load_addr + 1'b1;
                    end
                end
                default: state <= snes_glue_pkg::ld_idle;
            endcase
        end
    end

endmodule

/* hdl/snes_glue_if.sv */
// loader write and memory port request interfaces of the snes memory glue
interface load_wr_if;
    logic [7:0]                          data;     // image byte
    logic [snes_glue_pkg::mem_addr_w-1:0] addr;
    logic                                strobe;   // one cycle pulse writes data to addr
    logic                                active;   // loader in header or body phase

    modport src (output data, output addr, output strobe, output active);
    modport dst (input data, input addr, input strobe, input active);
endinterface

interface mem_req_if;
    logic [snes_glue_pkg::mem_addr_w-1:0] addr;
    logic [15:0]                         din;
    logic [1:0]                          ds;      // byte lanes with bit 1 the high byte
    logic                                port;
    logic                                rd;
    logic                                wr;
    snes_glue_pkg::req_src_e             source;  // trace only

    modport src (
        output addr,
        output din,
        output ds,
        output port,
        output rd,
        output wr,
        output source
    );
endinterface

/* hdl/snes_glue_pkg.sv */
// snes memory glue package with widths, load header length, address bases and shared enums
package snes_glue_pkg;

    // memory port and core address widths
    localparam int mem_addr_w  = 23;   // byte address on the memory port
    localparam int rom_addr_w  = 24;
    localparam int wram_addr_w = 17;   // 128KB work RAM
    localparam int vram_addr_w = 15;   // low bits of the 16-bit core VRAM address

    // cartridge image header skipped by the loader
    localparam int header_bytes = 64;
    localparam int header_cnt_w = $clog2(header_bytes);
    localparam logic [header_cnt_w-1:0] header_last = header_cnt_w'(header_bytes - 1);

    // work RAM sits at the top of the memory map
    localparam logic [5:0] wram_base = 6'b111111;

    // memory port select bit
    localparam logic port_rom  = 1'b0;
    localparam logic port_wram = 1'b1;

    // source of the request currently on the memory port
    typedef enum logic [1:0] {
        src_none,
        src_loader,
        src_wram,
        src_rom
    } req_src_e;

    // loader phases
    typedef enum logic [1:0] {
        ld_idle,
        ld_header,     // counting and dropping header bytes
        ld_body,       // image bytes go to memory
        ld_done
    } load_state_e;

endpackage
